//--- design/dmem_pkg.sv
package dmem_pkg;

    localparam int addr_w            = 17;
    localparam int mem_bytes         = 2 ** addr_w;
    localparam int data_w            = 32;
    localparam int word_bytes        = data_w / 8;           // lanes per word
    localparam logic [addr_w-1:0] mmio_trigger_addr = 17'h00100;

    // access mode, shared by loads and stores
    typedef enum logic [2:0] {
        op_none   = 3'd0,
        op_word   = 3'd1,
        op_half   = 3'd2,
        op_byte   = 3'd3,
        op_half_u = 3'd4,
        op_byte_u = 3'd5
    } mem_op_e;

    // request from a peer, held until granted
    typedef struct packed {
        logic              we;
        mem_op_e           op;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    // one-cycle response pulse
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] rdata;
    } mem_rsp_t;

    // byte lane request into the RAM, lane 0 is the lowest address
    typedef struct packed {
        logic                      we;
        logic [addr_w-1:0]         addr;
        logic [2:0]                nbytes;    // 0 to 4
        logic [word_bytes-1:0][7:0] lanes;
    } lane_req_t;

    // number of bytes an access touches, zero for no access
    function automatic logic [2:0] op_nbytes(mem_op_e op);
        case (op)
            op_word:
                return 3'd4;
            op_half, op_half_u:
                return 3'd2;
            op_byte, op_byte_u:
                return 3'd1;
            default:
                return 3'd0;
        endcase
    endfunction

endpackage

//--- design/access_format.sv
module access_format
    import dmem_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  mem_req_t                   req,
    input  logic                       valid,
    output lane_req_t                  ram_req,
    input  logic [word_bytes-1:0][7:0] ram_rdata,
    input  logic [data_w-1:0]          mmio_rdata,
    output logic [data_w-1:0]          rdata
);

    logic              is_mmio;
    mem_op_e           op_q;      // op of the load in flight
    logic              sel_q;     // load in flight hit the status word
    logic [data_w-1:0] word;

    assign is_mmio = (req.addr == mmio_trigger_addr);

    // request side
    always_comb
    begin
        ram_req.we     = valid && req.we;
        ram_req.addr   = req.addr;
        ram_req.lanes  = req.wdata;           // little-endian, low byte in lane 0
        ram_req.nbytes = op_nbytes(req.op);
        if (!valid || is_mmio)
            ram_req.nbytes = 3'd0;            // status address never reaches the RAM
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            op_q  <= op_none;
            sel_q <= 1'b0;
        end
        else
        begin
            op_q  <= (valid && !req.we) ? req.op : op_none;   // stores answer zero
            sel_q <= valid && is_mmio;
        end
    end

    // response side
    assign word = sel_q ? mmio_rdata : ram_rdata;

    always_comb
    begin
        case (op_q)
            op_word:
                rdata = word;
            op_half:
                rdata = {{16{word[15]}}, word[15:0]};
            op_byte:
                rdata = {{24{word[7]}}, word[7:0]};
            op_half_u:
                rdata = {16'b0, word[15:0]};
            op_byte_u:
                rdata = {24'b0, word[7:0]};
            default:
                rdata = '0;                   // op_none and unused codes
        endcase
    end

endmodule

//--- design/byte_ram.sv
module byte_ram
    import dmem_pkg::*;
(
    input  logic                       clk,
    input  lane_req_t                  req,
    output logic [word_bytes-1:0][7:0] rdata
);

    logic [7:0] mem [mem_bytes];

    // per-lane byte address, wraps at the top of memory
    logic [word_bytes-1:0][addr_w-1:0] lane_addr;

    always_comb
    begin
        for (int i = 0; i < word_bytes; i++)
            lane_addr[i] = req.addr + addr_w'(i);
    end

    // write the first nbytes lanes
    always_ff @(posedge clk)
    begin
        if (req.we)
        begin
            for (int i = 0; i < word_bytes; i++)
            begin
                if (i < int'(req.nbytes))
                    mem[lane_addr[i]] <= req.lanes[i];
            end
        end
    end

    // four bytes are always fetched; the formatter picks what it needs
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < word_bytes; i++)
            rdata[i] <= mem[lane_addr[i]];   // old data on a same-cycle write
    end

endmodule

//--- design/mmio_trigger.sv
module mmio_trigger
    import dmem_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  mem_req_t          req,
    input  logic              valid,
    input  logic              trigger,
    output logic [data_w-1:0] rdata
);

    logic sel;
    logic clr;
    logic flag;

    assign sel = valid && (req.addr == mmio_trigger_addr);
    assign clr = sel && req.we && (op_nbytes(req.op) != 3'd0) && req.wdata[0];

    // sticky flag, set wins over clear
    always_ff @(posedge clk)
    begin
        if (rst)
            flag <= 1'b0;
        else if (trigger)
            flag <= 1'b1;
        else if (clr)
            flag <= 1'b0;
    end

    // captured on a status load, flag in bit 0
    always_ff @(posedge clk)
    begin
        if (rst)
            rdata <= '0;
        else if (sel && !req.we)
            rdata <= data_w'(flag);
    end

endmodule

//--- design/mem_arbiter.sv
module mem_arbiter
    import dmem_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  mem_req_t          core_req,
    input  logic              core_valid,
    input  mem_req_t          eng_req,
    input  logic              eng_valid,
    output logic              core_gnt,
    output logic              eng_gnt,
    output mem_req_t          acc_req,
    input  logic [data_w-1:0] acc_rdata,
    output mem_rsp_t          core_rsp,
    output mem_rsp_t          eng_rsp
);

    logic core_own;   // core owns the response this cycle
    logic eng_own;

    // fixed priority, core first
    assign core_gnt = core_valid;
    assign eng_gnt  = eng_valid && !core_valid;
    assign acc_req  = core_valid ? core_req : eng_req;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            core_own <= 1'b0;
            eng_own  <= 1'b0;
        end
        else
        begin
            core_own <= core_gnt;
            eng_own  <= eng_gnt;
        end
    end

    // route the response only to its owner
    always_comb
    begin
        core_rsp.valid = core_own;
        core_rsp.rdata = core_own ? acc_rdata : '0;
        eng_rsp.valid  = eng_own;
        eng_rsp.rdata  = eng_own ? acc_rdata : '0;
    end

endmodule

//--- design/copy_engine.sv
module copy_engine
    import dmem_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [addr_w-1:0] src,
    input  logic [addr_w-1:0] dst,
    input  logic [7:0]        len,
    output mem_req_t          req,
    output logic              req_valid,
    input  logic              gnt,
    input  mem_rsp_t          rsp,
    output logic              busy,
    output logic              done
);

    typedef enum logic [1:0] {
        s_idle,
        s_read,
        s_wait,     // waits for the load and then the store response
        s_write
    } state_e;

    state_e            state;
    logic [addr_w-1:0] src_q;
    logic [addr_w-1:0] dst_q;
    logic [7:0]        cnt;       // words left, current one included
    logic [data_w-1:0] data_q;
    logic              wr_pend;   // waiting on the store response

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= s_idle;
            done    <= 1'b0;
            wr_pend <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                s_idle:
                    if (start)
                    begin
                        if (len == 8'd0)
                            done <= 1'b1;         // nothing to move
                        else
                            state <= s_read;
                    end
                s_read:
                    if (gnt)
                    begin
                        wr_pend <= 1'b0;
                        state   <= s_wait;
                    end
                s_wait:
                    if (rsp.valid)
                    begin
                        if (!wr_pend)
                            state <= s_write;
                        else if (cnt == 8'd1)
                        begin
                            state <= s_idle;
                            done  <= 1'b1;
                        end
                        else
                            state <= s_read;
                    end
                s_write:
                    if (gnt)
                    begin
                        wr_pend <= 1'b1;
                        state   <= s_wait;
                    end
                default:
                    state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == s_idle && start)
        begin
            src_q <= src;
            dst_q <= dst;
            cnt   <= len;
        end
        else if (state == s_wait && rsp.valid)
        begin
            if (!wr_pend)
                data_q <= rsp.rdata;              // word to store
            else
            begin
                src_q <= src_q + addr_w'(word_bytes);
                dst_q <= dst_q + addr_w'(word_bytes);
                cnt   <= cnt - 8'd1;
            end
        end
    end

    assign busy      = (state != s_idle);
    assign req_valid = (state == s_read) || (state == s_write);

    always_comb
    begin
        req.we    = (state == s_write);
        req.op    = op_word;
        req.addr  = (state == s_write) ? dst_q : src_q;
        req.wdata = (state == s_write) ? data_q : '0;
    end

endmodule

//--- design/dmem_subsys.sv
module dmem_subsys
    import dmem_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  mem_req_t          core_req,
    input  logic              core_req_valid,
    output logic              core_gnt,
    output mem_rsp_t          core_rsp,
    input  logic              trigger,
    input  logic              copy_start,
    input  logic [addr_w-1:0] copy_src,
    input  logic [addr_w-1:0] copy_dst,
    input  logic [7:0]        copy_len,
    output logic              copy_busy,
    output logic              copy_done
);

    mem_req_t                   eng_req;
    logic                       eng_valid;
    logic                       eng_gnt;
    mem_rsp_t                   eng_rsp;
    mem_req_t                   acc_req;
    logic                       acc_valid;
    logic [data_w-1:0]          acc_rdata;
    lane_req_t                  ram_req;
    logic [word_bytes-1:0][7:0] ram_rdata;
    logic [data_w-1:0]          mmio_rdata;

    assign acc_valid = core_gnt || eng_gnt;   // one access per granted cycle

    mem_arbiter mem_arbiter_i (
        .clk        (clk),
        .rst        (rst),
        .core_req   (core_req),
        .core_valid (core_req_valid),
        .eng_req    (eng_req),
        .eng_valid  (eng_valid),
        .core_gnt   (core_gnt),
        .eng_gnt    (eng_gnt),
        .acc_req    (acc_req),
        .acc_rdata  (acc_rdata),
        .core_rsp   (core_rsp),
        .eng_rsp    (eng_rsp)
    );

    copy_engine copy_engine_i (
        .clk       (clk),
        .rst       (rst),
        .start     (copy_start),
        .src       (copy_src),
        .dst       (copy_dst),
        .len       (copy_len),
        .req       (eng_req),
        .req_valid (eng_valid),
        .gnt       (eng_gnt),
        .rsp       (eng_rsp),
        .busy      (copy_busy),
        .done      (copy_done)
    );

    access_format access_format_i (
        .clk        (clk),
        .rst        (rst),
        .req        (acc_req),
        .valid      (acc_valid),
        .ram_req    (ram_req),
        .ram_rdata  (ram_rdata),
        .mmio_rdata (mmio_rdata),
        .rdata      (acc_rdata)
    );

    byte_ram byte_ram_i (
        .clk   (clk),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

    mmio_trigger mmio_trigger_i (
        .clk     (clk),
        .rst     (rst),
        .req     (acc_req),
        .valid   (acc_valid),
        .trigger (trigger),
        .rdata   (mmio_rdata)
    );

endmodule

//--- tb/dmem_subsys_props.sv
module dmem_subsys_props
    import dmem_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     core_gnt,
    input logic     eng_gnt,
    input mem_rsp_t core_rsp,
    input mem_rsp_t eng_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    grant_one_peer: assert property (@(posedge clk) disable iff (rst)
        !(core_gnt && eng_gnt))
    else
    begin
        $error("both peers granted in the same cycle");
        fail_count++;
    end

    // response pulse exactly one cycle after each grant
    rsp_after_grant: assert property (@(posedge clk) disable iff (rst)
        (core_rsp.valid == $past(core_gnt)) && (eng_rsp.valid == $past(eng_gnt)))
    else
    begin
        $error("response valid does not follow its grant by one cycle");
        fail_count++;
    end

    rsp_one_peer: assert property (@(posedge clk) disable iff (rst)
        !(core_rsp.valid && eng_rsp.valid))
    else
    begin
        $error("response valid sent to both peers");
        fail_count++;
    end

endmodule

bind mem_arbiter dmem_subsys_props props_i (
    .clk      (clk),
    .rst      (rst),
    .core_gnt (core_gnt),
    .eng_gnt  (eng_gnt),
    .core_rsp (core_rsp),
    .eng_rsp  (eng_rsp)
);

//--- tb/dmem_subsys_tb.sv
module dmem_subsys_tb
    import dmem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              rst;
    mem_req_t          core_req;
    logic              core_req_valid;
    logic              core_gnt;
    mem_rsp_t          core_rsp;
    logic              trigger;
    logic              copy_start;
    logic [addr_w-1:0] copy_src;
    logic [addr_w-1:0] copy_dst;
    logic [7:0]        copy_len;
    logic              copy_busy;
    logic              copy_done;

    logic [7:0]  model [mem_bytes];   // reference byte image
    logic        flag_model = 1'b0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          done_seen = 0;
    int          test_ops = 170;      // core and engine accesses over all tests
    int          cycles_per_op = 20;

    dmem_subsys dmem_subsys_i (
        .clk            (clk),
        .rst            (rst),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_gnt       (core_gnt),
        .core_rsp       (core_rsp),
        .trigger        (trigger),
        .copy_start     (copy_start),
        .copy_src       (copy_src),
        .copy_dst       (copy_dst),
        .copy_len       (copy_len),
        .copy_busy      (copy_busy),
        .copy_done      (copy_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        repeat (16 + test_ops * cycles_per_op) @(posedge clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // busy must already be low in the done cycle
    always @(posedge clk)
    begin
        if (copy_done === 1'b1)
        begin
            done_seen <= done_seen + 1;
            assert (!copy_busy)
            else
            begin
                $display("copy busy still high while done pulses");
                errors++;
            end
        end
    end

    function automatic int access_bytes(input logic [2:0] op);
        case (op)
            3'd1:
                return 4;
            3'd2, 3'd4:
                return 2;
            3'd3, 3'd5:
                return 1;
            default:
                return 0;
        endcase
    endfunction

    // little-endian assembly, then extension by mode
    function automatic logic [31:0] expect_load(input logic [2:0] op,
                                                input logic [addr_w-1:0] addr);
        logic [31:0] w;
        if (addr == mmio_trigger_addr)
            w = {31'b0, flag_model};
        else
            for (int k = 0; k < 4; k++)
                w[8*k +: 8] = model[addr_w'(addr + k)];
        case (op)
            3'd1:
                return w;
            3'd2:
                return 32'($signed(w[15:0]));
            3'd3:
                return 32'($signed(w[7:0]));
            3'd4:
                return {16'h0, w[15:0]};
            3'd5:
                return {24'h0, w[7:0]};
            default:
                return 32'h0;
        endcase
    endfunction

    function automatic logic [addr_w-1:0] rand_addr();
        return addr_w'(32'h200 + $urandom % (mem_bytes - 32'h204));
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // one core access starting at a rising edge
    task automatic core_access(input logic we, input logic [2:0] op,
                               input logic [addr_w-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        mem_req_t req;
        int       waited;
        req.we    = we;
        req.op    = mem_op_e'(op);
        req.addr  = addr;
        req.wdata = wdata;
        core_req       <= req;
        core_req_valid <= 1'b1;
        waited = 0;
        @(posedge clk);
        while (!core_gnt && waited < 16)
        begin
            @(posedge clk);
            waited++;
        end
        assert (core_gnt)
        else
        begin
            $display("core request to %05h was never granted", addr);
            errors++;
        end
        assert (waited == 0)
        else
        begin
            $display("core request to %05h waited %0d cycles for its grant", addr, waited);
            errors++;
        end
        core_req_valid <= 1'b0;
        @(posedge clk);
        assert (core_rsp.valid)
        else
        begin
            $display("no core response one cycle after the grant for %05h", addr);
            errors++;
        end
        rdata = core_rsp.rdata;
    endtask

    task automatic load_check(input logic [2:0] op, input logic [addr_w-1:0] addr,
                              output logic [31:0] r);
        core_access(1'b0, op, addr, 32'h0, r);
        check_value($sformatf("core_rsp.rdata op %0d addr %05h", op, addr), r,
                    expect_load(op, addr));
    endtask

    task automatic store_check(input logic [2:0] op, input logic [addr_w-1:0] addr,
                               input logic [31:0] wdata);
        logic [31:0] r;
        core_access(1'b1, op, addr, wdata, r);
        check_value($sformatf("core_rsp.rdata store addr %05h", addr), r, 32'h0);
        if (addr == mmio_trigger_addr)
        begin
            if (access_bytes(op) != 0 && wdata[0])
                flag_model = 1'b0;
        end
        else
            for (int k = 0; k < access_bytes(op); k++)
                model[addr_w'(addr + k)] = wdata[8*k +: 8];
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before)
            $display("%s: ok", name);
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic pulse_trigger();
        trigger <= 1'b1;
        @(posedge clk);
        trigger <= 1'b0;
        flag_model = 1'b1;
    endtask

    task automatic word_round_trip();
        logic [addr_w-1:0] a;
        logic [31:0]       w;
        logic [31:0]       r;
        int                err0;
        err0 = errors;
        for (int i = 0; i < 8; i++)
        begin
            a = rand_addr();
            w = $urandom;
            store_check(3'd1, a, w);
            load_check(3'd1, a, r);
            for (int k = 0; k < 4; k++)
            begin
                load_check(3'd5, addr_w'(a + k), r);
                check_value("core_rsp.rdata byte lane", r,
                            {24'h0, w[8*k +: 8]});   // lowest byte first
            end
        end
        finish_test("word_round_trip", err0);
    endtask

    task automatic extension_modes();
        logic [addr_w-1:0] a;
        logic [31:0]       w;
        logic [31:0]       r;
        logic              top;
        int                err0;
        err0 = errors;
        for (int s = 0; s < 2; s++)
        begin
            top   = (s == 1);
            a     = rand_addr();
            w     = $urandom;
            w[7]  = top;
            w[15] = top;
            store_check(3'd1, a, w);
            for (int op = 0; op < 8; op++)
                load_check(3'(op), a, r);          // includes none, 6 and 7
            store_check(3'd0, a, ~w);              // no access
            store_check(3'd6, a, ~w);
            store_check(3'd7, a, ~w);
            load_check(3'd1, a, r);
            store_check(3'd5, addr_w'(a + 3), top ? 32'hC5 : 32'h45);
            load_check(3'd1, a, r);
            load_check(3'd3, addr_w'(a + 3), r);
        end
        finish_test("extension_modes", err0);
    endtask

    task automatic wrap_around();
        logic [addr_w-1:0] a;
        logic [31:0]       w;
        logic [31:0]       r;
        int                err0;
        err0 = errors;
        a = addr_w'(mem_bytes - 1);
        w = $urandom;
        store_check(3'd1, a, w);
        load_check(3'd1, a, r);
        for (int k = 0; k < 4; k++)
        begin
            load_check(3'd5, addr_w'(a + k), r);   // top byte, then 0, 1, 2
            check_value("core_rsp.rdata wrapped byte", r, {24'h0, w[8*k +: 8]});
        end
        finish_test("wrap_around", err0);
    endtask

    task automatic status_word();
        logic [31:0] r;
        int          err0;
        err0 = errors;
        store_check(3'd1, 17'h000FD, 32'hA1B2C3D4);   // RAM byte 0x100 gets A1
        load_check(3'd1, mmio_trigger_addr, r);
        pulse_trigger();
        load_check(3'd1, mmio_trigger_addr, r);
        load_check(3'd3, mmio_trigger_addr, r);       // sticky
        store_check(3'd1, mmio_trigger_addr, 32'h2);  // bit 0 clear keeps the flag
        load_check(3'd1, mmio_trigger_addr, r);
        store_check(3'd1, mmio_trigger_addr, 32'h1);
        load_check(3'd1, mmio_trigger_addr, r);
        load_check(3'd1, 17'h000FD, r);
        check_value("core_rsp.rdata ram word at 000fd", r, 32'hA1B2C3D4);
        load_check(3'd4, 17'h000FF, r);
        check_value("core_rsp.rdata ram half at 000ff", r, 32'h0000A1B2);
        finish_test("status_word", err0);
    endtask

    task automatic block_copy();
        logic [7:0]        len;
        logic [addr_w-1:0] src;
        logic [addr_w-1:0] dst;
        logic [31:0]       r;
        int                err0;
        int                done0;
        int                guard;
        err0 = errors;
        len  = 8'(4 + $urandom % 9);
        src  = 17'h04000 + addr_w'(4 * ($urandom % 32'h400));
        dst  = 17'h10000 + addr_w'(4 * ($urandom % 32'h400));
        for (int i = 0; i < int'(len); i++)
            store_check(3'd1, addr_w'(src + 4 * i), $urandom);
        done0 = done_seen;
        copy_src   <= src;
        copy_dst   <= dst;
        copy_len   <= len;
        copy_start <= 1'b1;
        @(posedge clk);
        copy_start <= 1'b0;
        @(posedge clk);
        assert (copy_busy)
        else
        begin
            $display("copy engine did not raise busy after start");
            errors++;
        end
        for (int i = 0; i < 6; i++)
        begin
            if (i == 3)
                store_check(3'd1, addr_w'(17'h08000 + 4 * i), $urandom);
            else
                load_check(3'd1, addr_w'(src + 4 * ($urandom % len)), r);
        end
        guard = 0;
        while (done_seen == done0 && guard < 400)
        begin
            @(posedge clk);
            guard++;
        end
        repeat (3) @(posedge clk);
        assert (done_seen == done0 + 1)
        else
        begin
            $display("copy done pulsed %0d times instead of once", done_seen - done0);
            errors++;
        end
        for (int i = 0; i < int'(len); i++)
            for (int k = 0; k < 4; k++)
                model[addr_w'(dst + 4 * i + k)] = model[addr_w'(src + 4 * i + k)];
        for (int i = 0; i < int'(len); i++)
            load_check(3'd1, addr_w'(dst + 4 * i), r);
        copy_len   <= 8'd0;                      // empty copy
        copy_start <= 1'b1;
        @(posedge clk);
        copy_start <= 1'b0;
        @(posedge clk);
        assert (copy_done && !copy_busy)
        else
        begin
            $display("empty copy did not finish one cycle after start");
            errors++;
        end
        finish_test("block_copy", err0);
    endtask

    task automatic response_timing();
        logic [addr_w-1:0] a;
        logic [31:0]       r;
        int                err0;
        err0 = errors;
        a = rand_addr();
        store_check(3'd1, a, $urandom);
        for (int i = 0; i < 4; i++)
        begin
            load_check(3'd1, a, r);
            @(posedge clk);                      // idle cycle without a pulse
            assert (!core_rsp.valid)
            else
            begin
                $display("core response valid without a grant");
                errors++;
            end
        end
        finish_test("response_timing", err0);
    endtask

    initial
    begin
        int total;
        void'($urandom(32'h522));
        rst            = 1'b1;
        core_req       = '0;
        core_req_valid = 1'b0;
        trigger        = 1'b0;
        copy_start     = 1'b0;
        copy_src       = '0;
        copy_dst       = '0;
        copy_len       = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        word_round_trip();
        extension_modes();
        wrap_around();
        status_word();
        block_copy();
        response_timing();
        repeat (2) @(posedge clk);
        total = errors + int'(dmem_subsys_i.mem_arbiter_i.props_i.fail_count);
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total);
        if (total == 0 && tests_failed == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tb.f
design/dmem_pkg.sv
design/access_format.sv
design/byte_ram.sv
design/mmio_trigger.sv
design/mem_arbiter.sv
design/copy_engine.sv
design/dmem_subsys.sv
tb/dmem_subsys_props.sv
tb/dmem_subsys_tb.sv
